// File: common/tpu_pkg.sv
`default_nettype none

package tpu_pkg;

    // lane and row geometry
    localparam int DWIDTH       = 8;
    localparam int ACC_WIDTH    = 16;
    localparam int MAT_MUL_SIZE = 4;

    // width of the run-time requantization shift
    localparam int SHIFT_WIDTH  = 4;

    // one signed activation lane
    typedef logic signed [DWIDTH-1:0] data_t;

    // one signed accumulator lane from the array
    typedef logic signed [ACC_WIDTH-1:0] acc_t;

    // packed data row, lane 0 sits in the low bits
    typedef logic [MAT_MUL_SIZE*DWIDTH-1:0] row_t;

    // packed accumulator row, same lane order as row_t
    typedef logic [MAT_MUL_SIZE*ACC_WIDTH-1:0] acc_row_t;

    // arithmetic right shift applied before saturation
    typedef logic [SHIFT_WIDTH-1:0] shift_t;

endpackage

`default_nettype wire

// File: hw/acc_requant.sv
`default_nettype none

module acc_requant (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              in_valid,
    input  wire tpu_pkg::acc_row_t in_acc,
    input  wire tpu_pkg::shift_t   shift,
    output logic                   row_wr,
    output tpu_pkg::row_t          row_wdata
);

    import tpu_pkg::*;

    // saturation bounds of a data lane, held in accumulator width
    localparam acc_t SAT_MAX = acc_t'((1 << (DWIDTH - 1)) - 1);
    localparam acc_t SAT_MIN = acc_t'(-(1 << (DWIDTH - 1)));

    acc_t shifted [MAT_MUL_SIZE];
    row_t sat_row;

    // per lane: arithmetic shift, then clamp into the data range
    always_comb begin
        for (int i = 0; i < MAT_MUL_SIZE; i++) begin
            shifted[i] = acc_t'(in_acc[i*ACC_WIDTH +: ACC_WIDTH]) >>> shift;
            if (shifted[i] > SAT_MAX) begin
                sat_row[i*DWIDTH +: DWIDTH] = data_t'(SAT_MAX);
            end else if (shifted[i] < SAT_MIN) begin
                sat_row[i*DWIDTH +: DWIDTH] = data_t'(SAT_MIN);
            end else begin
                sat_row[i*DWIDTH +: DWIDTH] = data_t'(shifted[i]);
            end
        end
    end

    // write strobe follows in_valid by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            row_wr <= 1'b0;
        end else begin
            row_wr <= in_valid;
        end
    end

    // payload register, only loaded with a new row
    always_ff @(posedge clk) begin
        if (in_valid) begin
            row_wdata <= sat_row;
        end
    end

endmodule

`default_nettype wire

// File: hw/row_fifo.sv
`default_nettype none

module row_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire logic          row_wr,
    input  wire tpu_pkg::row_t row_wdata,
    input  wire logic          row_pop,
    output tpu_pkg::row_t      row_head,
    output logic               empty,
    output logic               overflow
);

    import tpu_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = FIFO_DEPTH[PTR_W:0];

    row_t             mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             wr_en;

    assign full  = (count == FULL_COUNT);
    assign empty = (count == '0);

    // a pop in the same cycle frees the slot, so a full FIFO still accepts
    assign wr_en = row_wr && (!full || row_pop);

    // head row, meaningful only while not empty
    assign row_head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= row_wdata;
        end
    end

    // pointers wrap naturally for a power-of-two depth
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (row_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, row_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // sticky drop flag, cleared only by reset
    always_ff @(posedge clk) begin
        if (reset) begin
            overflow <= 1'b0;
        end else if (row_wr && !wr_en) begin
            overflow <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: activation/activation.sv
`default_nettype none

module activation (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire logic          enable_activation,
    input  wire logic          activation_type,
    input  wire logic          stall,
    input  wire logic          empty,
    input  wire tpu_pkg::row_t row_head,
    output logic               row_pop,
    output tpu_pkg::row_t      out_data,
    output logic               out_data_available,
    output logic               done_activation
);

    import tpu_pkg::*;

    row_t act_row;
    row_t out_activation;
    logic out_data_valid;
    logic finish_activation;

    // piecewise-linear tanh on one lane, odd-symmetric around zero
    function automatic data_t tanh_lane(input data_t x);
        int wide;
        if (x >= 90) begin
            wide = 127;
        end else if (x >= 39) begin
            wide = 99;
        end else if (x >= 28) begin
            wide = 2 * x + 46;
        end else if (x >= 16) begin
            wide = 3 * x + 18;
        end else if (x >= 1) begin
            wide = 4 * x;
        end else if (x == 0) begin
            wide = 0;
        end else if (x > -16) begin
            wide = 4 * x;
        end else if (x > -28) begin
            wide = 3 * x - 18;
        end else if (x > -39) begin
            wide = 2 * x - 46;
        end else if (x > -90) begin
            wide = -99;
        end else begin
            wide = -127;
        end
        // every segment lands inside the data range
        return data_t'(wide);
    endfunction

    // ReLU clips negative lanes to zero
    function automatic data_t relu_lane(input data_t x);
        data_t result;
        if (x < 0) begin
            result = '0;
        end else begin
            result = x;
        end
        return result;
    endfunction

    // pop whenever a row is waiting and downstream is not stalled
    assign row_pop = !empty && !stall;

    always_comb begin
        for (int i = 0; i < MAT_MUL_SIZE; i++) begin
            if (activation_type) begin
                act_row[i*DWIDTH +: DWIDTH] = tanh_lane(data_t'(row_head[i*DWIDTH +: DWIDTH]));
            end else begin
                act_row[i*DWIDTH +: DWIDTH] = relu_lane(data_t'(row_head[i*DWIDTH +: DWIDTH]));
            end
        end
    end

    // result, valid and done all drop back to zero on idle cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            out_activation    <= '0;
            out_data_valid    <= 1'b0;
            finish_activation <= 1'b0;
        end else if (row_pop) begin
            out_activation    <= act_row;
            out_data_valid    <= 1'b1;
            finish_activation <= 1'b1;
        end else begin
            out_activation    <= '0;
            out_data_valid    <= 1'b0;
            finish_activation <= 1'b0;
        end
    end

    // bypass forwards the head row in the pop cycle itself
    assign out_data           = enable_activation ? out_activation : row_head;
    assign out_data_available = enable_activation ? out_data_valid : row_pop;

    // done stays high when the block is bypassed
    assign done_activation    = enable_activation ? finish_activation : 1'b1;

endmodule

`default_nettype wire

// File: hw/activation_stage.sv
`default_nettype none

module activation_stage #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              in_valid,
    input  wire tpu_pkg::acc_row_t in_acc,
    input  wire tpu_pkg::shift_t   shift,
    input  wire logic              enable_activation,
    input  wire logic              activation_type,
    input  wire logic              stall,
    output tpu_pkg::row_t          out_data,
    output logic                   out_data_available,
    output logic                   done_activation,
    output logic                   overflow
);

    import tpu_pkg::*;

    logic row_wr;
    row_t row_wdata;
    logic row_pop;
    row_t row_head;
    logic empty;

    // accumulator rows in, requantized rows out
    acc_requant i_acc_requant (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_acc    (in_acc),
        .shift     (shift),
        .row_wr    (row_wr),
        .row_wdata (row_wdata)
    );

    // absorbs rows while the consumer is stalled
    row_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_row_fifo (
        .clk       (clk),
        .reset     (reset),
        .row_wr    (row_wr),
        .row_wdata (row_wdata),
        .row_pop   (row_pop),
        .row_head  (row_head),
        .empty     (empty),
        .overflow  (overflow)
    );

    activation i_activation (
        .clk                (clk),
        .reset              (reset),
        .enable_activation  (enable_activation),
        .activation_type    (activation_type),
        .stall              (stall),
        .empty              (empty),
        .row_head           (row_head),
        .row_pop            (row_pop),
        .out_data           (out_data),
        .out_data_available (out_data_available),
        .done_activation    (done_activation)
    );

endmodule

`default_nettype wire

// File: sim/activation_stage_tb.sv
`default_nettype none

module activation_stage_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import tpu_pkg::*;

    localparam int    FIFO_DEPTH    = 4;
    localparam int    RESET_CYCLES  = 10;
    localparam int    DRAIN_TIMEOUT = 200;
    localparam int    SETTLE_CYCLES = 3;
    localparam int    MAX_GAP       = 2;
    localparam string VECTOR_FILE   = "sim/activation_stage_vectors.txt";

    logic     clk = 1'b0;
    logic     reset;
    logic     in_valid;
    acc_row_t in_acc;
    shift_t   shift;
    logic     enable_activation;
    logic     activation_type;
    logic     stall;
    row_t     out_data;
    logic     out_data_available;
    logic     done_activation;
    logic     overflow;

    // one entry per vector line
    int       vec_test[$];
    logic     vec_enable[$];
    logic     vec_type[$];
    shift_t   vec_shift[$];
    int       vec_stall[$];
    acc_row_t vec_acc[$];
    row_t     vec_exp[$];
    logic     vec_drop[$];

    // rows still owed by the DUT, oldest first
    row_t     expected_rows[$];
    int       errors;
    int       checks;
    int       tests_run;
    logic     overflow_expected;
    logic     timed_out;

    // expected write strobe, occupancy and pop of the row path
    logic     model_wr;
    int       model_count;
    logic     model_pop_prev;

    always #4 clk = ~clk;

    activation_stage #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_dut (
        .clk                (clk),
        .reset              (reset),
        .in_valid           (in_valid),
        .in_acc             (in_acc),
        .shift              (shift),
        .enable_activation  (enable_activation),
        .activation_type    (activation_type),
        .stall              (stall),
        .out_data           (out_data),
        .out_data_available (out_data_available),
        .done_activation    (done_activation),
        .overflow           (overflow)
    );

    function automatic acc_row_t pack_acc(input int l0, input int l1, input int l2, input int l3);
        return {acc_t'(l3), acc_t'(l2), acc_t'(l1), acc_t'(l0)};
    endfunction

    function automatic row_t pack_row(input int l0, input int l1, input int l2, input int l3);
        return {data_t'(l3), data_t'(l2), data_t'(l1), data_t'(l0)};
    endfunction

    task automatic check_row(input row_t expected, input row_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0d ns: output row mismatch, expected %h, got %h",
                     $time, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0d ns: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic load_vectors(output logic ok);
        int    fd;
        int    count;
        int    f [14];
        string line;
        ok = 1'b0;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("could not open the vector file %s", VECTOR_FILE);
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.getc(0) == "#") begin
                continue;
            end
            count = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                            f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
            if (count == 14) begin
                vec_test.push_back(f[0]);
                vec_enable.push_back(f[1] != 0);
                vec_type.push_back(f[2] != 0);
                vec_shift.push_back(shift_t'(f[3]));
                vec_stall.push_back(f[4]);
                vec_acc.push_back(pack_acc(f[5], f[6], f[7], f[8]));
                vec_exp.push_back(pack_row(f[9], f[10], f[11], f[12]));
                vec_drop.push_back(f[13] != 0);
            end else if (count > 0) begin
                $display("malformed line in the vector file: %s", line);
                $fclose(fd);
                return;
            end
        end
        $fclose(fd);
        ok = (vec_test.size() != 0);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    // stalled rows keep stall high through their gap, so a burst never drains early
    task automatic send_row(input int idx);
        int gap;
        @(posedge clk);
        enable_activation <= vec_enable[idx];
        activation_type   <= vec_type[idx];
        shift             <= vec_shift[idx];
        stall             <= (vec_stall[idx] != 0);
        in_valid          <= 1'b1;
        in_acc            <= vec_acc[idx];
        if (vec_drop[idx]) begin
            overflow_expected = 1'b1;
        end else begin
            expected_rows.push_back(vec_exp[idx]);
        end
        if (vec_stall[idx] != 0) begin
            gap = vec_stall[idx];
        end else begin
            gap = $urandom_range(MAX_GAP);
        end
        idle_cycles(gap);
    endtask

    task automatic wait_drain(output logic drained);
        int cycles;
        cycles = 0;
        while (expected_rows.size() != 0 && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        drained = (expected_rows.size() == 0);
    endtask

    task automatic run_test(input int first, input int last);
        int   errors_before;
        logic drained;
        errors_before = errors;
        for (int i = first; i <= last; i++) begin
            send_row(i);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        stall    <= 1'b0;
        wait_drain(drained);
        if (!drained) begin
            timed_out = 1'b1;
            errors++;
            $display("timeout in test %0d: %0d output rows never arrived within %0d cycles",
                     vec_test[first], expected_rows.size(), DRAIN_TIMEOUT);
        end
        // let the activation registers clear before the mode can change
        repeat (SETTLE_CYCLES) @(posedge clk);
        check_flag("overflow", overflow_expected, overflow);
        tests_run++;
        $display("test %0d: %0d rows, %0d errors", vec_test[first], last - first + 1,
                 errors - errors_before);
    endtask

    // outputs are sampled on the falling edge, away from the driving edge
    always @(negedge clk) begin
        logic pop_now;
        logic available_expected;
        if (reset) begin
            model_wr       = 1'b0;
            model_count    = 0;
            model_pop_prev = 1'b0;
        end else begin
            // a row is popped while one is held and stall is low
            pop_now            = (model_count != 0) && !stall;
            available_expected = enable_activation ? model_pop_prev : pop_now;
            check_flag("out_data_available", available_expected, out_data_available);
            check_flag("done_activation", enable_activation ? model_pop_prev : 1'b1,
                       done_activation);
            if (out_data_available) begin
                if (expected_rows.size() == 0) begin
                    errors++;
                    $display("an output row %h arrived when no row was expected", out_data);
                end else begin
                    check_row(expected_rows.pop_front(), out_data);
                end
            end
            // write lands one cycle after in_valid, dropped only when full without a pop
            if (model_wr && (model_count < FIFO_DEPTH || pop_now)) begin
                model_count++;
            end
            if (pop_now) begin
                model_count--;
            end
            model_wr       = in_valid;
            model_pop_prev = pop_now;
        end
    end

    initial begin
        logic loaded;
        int   first;
        void'($urandom(23));
        errors            = 0;
        checks            = 0;
        tests_run         = 0;
        overflow_expected = 1'b0;
        timed_out         = 1'b0;
        reset             = 1'b1;
        in_valid          = 1'b0;
        in_acc            = '0;
        shift             = '0;
        enable_activation = 1'b1;
        activation_type   = 1'b0;
        stall             = 1'b0;
        load_vectors(loaded);
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag("out_data_available after reset", 1'b0, out_data_available);
        check_flag("overflow after reset", 1'b0, overflow);
        check_flag("done_activation after reset", 1'b0, done_activation);
        if (loaded) begin
            first = 0;
            for (int i = 0; i < vec_test.size() && !timed_out; i++) begin
                // a test ends where the id changes
                if (i == vec_test.size() - 1 || vec_test[i + 1] != vec_test[i]) begin
                    run_test(first, i);
                    first = i + 1;
                end
            end
        end else begin
            errors++;
            $display("no test vectors could be loaded");
        end
        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/activation_stage_vectors.txt
# id enable type shift stall acc0 acc1 acc2 acc3 exp0 exp1 exp2 exp3 drop
# type 0 is ReLU, 1 is tanh; stall > 0 holds stall high that many cycles after the row
# 1: ReLU with saturation at shift 0
1 1 0 0 0 10 -10 127 -128 10 0 127 0 0
1 1 0 0 0 300 -300 0 1 127 0 0 1 0
# 2: ReLU after arithmetic shifts, rounding toward minus infinity
2 1 0 4 0 1600 -1600 2047 2048 100 0 127 127 0
2 1 0 4 0 2032 2031 -2048 -2049 127 126 0 0 0
2 1 0 4 0 15 -1 -17 32767 0 0 0 127 0
2 1 0 1 0 255 256 -256 -257 127 127 0 0 0
# 3: tanh segment boundaries on both signs
3 1 1 0 0 89 90 38 39 99 127 122 99 0
3 1 1 0 0 28 27 16 15 102 99 66 60 0
3 1 1 0 0 1 0 -1 -15 4 0 -4 -60 0
3 1 1 0 0 -16 -27 -28 -38 -66 -99 -102 -122 0
3 1 1 0 0 -39 -89 -90 -128 -99 -99 -127 -127 0
3 1 1 0 0 127 2 20 -5 127 8 78 -20 0
3 1 1 2 0 400 -400 120 -64 127 -127 106 -66 0
# 4: bypass shows the requantized row unchanged
4 0 0 0 0 5 -5 200 -200 5 -5 127 -128 0
4 0 0 0 0 100 -100 0 -1 100 -100 0 -1 0
4 0 0 3 0 1000 -1000 8 -9 125 -125 1 -2 0
4 0 1 15 0 32767 -32768 16384 -1 0 -1 0 -1 0
4 0 1 0 0 50 -50 90 -90 50 -50 90 -90 0
# 5: back-pressure, four rows fill the FIFO under stall
5 1 0 0 1 1 2 3 4 1 2 3 4 0
5 1 0 0 1 5 -6 7 -8 5 0 7 0 0
5 1 0 0 1 9 10 11 12 9 10 11 12 0
5 1 0 0 3 -13 14 -15 16 0 14 0 16 0
# 6: unstalled stream with random gaps
6 1 0 0 0 10 20 30 40 10 20 30 40 0
6 1 0 0 0 -1 -2 -3 -4 0 0 0 0 0
6 1 0 0 0 50 -60 70 -80 50 0 70 0 0
6 1 0 0 0 127 -128 1 -1 127 0 1 0 0
6 1 0 0 0 33 44 -55 66 33 44 0 66 0
# 7: fifth row under stall is dropped and raises overflow
7 1 0 0 1 21 22 23 24 21 22 23 24 0
7 1 0 0 1 31 32 33 34 31 32 33 34 0
7 1 0 0 1 41 42 43 44 41 42 43 44 0
7 1 0 0 1 51 52 53 54 51 52 53 54 0
7 1 0 0 3 61 62 63 64 0 0 0 0 1
# 8: path still works, overflow stays high
8 1 0 0 0 7 -7 70 -70 7 0 70 0 0
# 9: bypass under back-pressure
9 0 0 0 1 3 -3 9 -9 3 -3 9 -9 0
9 0 0 0 2 60 61 62 63 60 61 62 63 0

// File: activation_stage.f
common/tpu_pkg.sv
hw/acc_requant.sv
hw/row_fifo.sv
activation/activation.sv
hw/activation_stage.sv
sim/activation_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module activation_stage_tb \
    -f activation_stage.f \
    -o activation_stage_sim

./obj_dir/activation_stage_sim > sim.log
cat sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation finished without a reported failure"
exit 0
